//--- all.f
rtl/hififo_pkg.sv
rtl/hififo_rc_if.sv
rtl/reorder_ram.sv
rtl/fwft_fifo.sv
rtl/fetch_descriptor.sv
rtl/request_pacer.sv
rtl/completion_reorder.sv
rtl/pcie_from_pc_fifo.sv
bench/tb_clock_gen.sv
bench/tb_pcie_from_pc_fifo.sv

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock and power-on reset
module tb_clock_gen #(
   parameter int HALF_PERIOD = 10,   // 20 ns period
   parameter int RESET_CYCLES = 8
) (
   output logic o_clock,
   output logic o_reset
);

   initial begin
      o_clock = 1'b0;
      forever #(HALF_PERIOD) o_clock = ~o_clock;
   end

   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clock);
      @(negedge o_clock);
      o_reset = 1'b0;   // released away from the sampling edge
   end

endmodule

`default_nettype wire

//--- bench/tb_pcie_from_pc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_from_pc_fifo;

   localparam logic [3:0] CHANNEL = 4'd0;
   localparam int MAX_OUT = 6;          // blocks in flight
   localparam int MIN_GAP = 4;          // cycles between acceptances

   logic clock, reset;
   logic i_pio_wvalid, i_rc_valid, i_rr_ready, i_fifo_read;
   logic [63:0] i_rx_data;
   logic [7:0] i_rc_tag;
   logic [5:0] i_rc_index;
   logic o_rr_valid, o_fifo_valid;
   logic [63:0] o_rr_addr, o_fifo_data;
   logic [2:0] o_rr_tag;
   logic [31:0] o_status;
   logic [1:0] o_interrupt;

   logic [31:0] rng;
   logic [63:0] pio_q[$];     // pio words waiting for the rx bus
   logic [63:0] exp_addr[$];  // block addresses still to be requested
   logic [63:0] exp_words[$]; // output words in request order
   logic [63:0] blk_addr[$];  // accepted blocks not fully completed
   logic [2:0] blk_tag[$];
   logic [63:0] blk_sent[$];  // words already returned, one bit each
   int errors, cycle, n_acc, last_acc, words_read, credited;
   int n_desc_nz, n_drop, n_int0, n_int1, low_stretch;
   bit hold_ready, timed_out;

   tb_clock_gen clkgen (.o_clock(clock), .o_reset(reset));

   pcie_from_pc_fifo #(.CHANNEL(CHANNEL), .DESC_DEPTH_LOG2(4), .OUT_DEPTH_LOG2(4)) DUT (
      .clock        (clock),
      .reset        (reset),
      .i_pio_wvalid (i_pio_wvalid),
      .i_rx_data    (i_rx_data),
      .i_rc_tag     (i_rc_tag),
      .i_rc_index   (i_rc_index),
      .i_rc_valid   (i_rc_valid),
      .o_rr_valid   (o_rr_valid),
      .o_rr_addr    (o_rr_addr),
      .o_rr_tag     (o_rr_tag),
      .i_rr_ready   (i_rr_ready),
      .i_fifo_read  (i_fifo_read),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid),
      .o_status     (o_status),
      .o_interrupt  (o_interrupt)
   );

   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);   // xorshift32
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [54:0] random_block();
      logic [31:0] hi, lo;
      hi = next_random();
      lo = next_random();
      return {hi[22:0], lo};
   endfunction

   // completer payload, byte address of the word xor a per-tag pattern
   function automatic logic [63:0] word_value(input logic [63:0] addr, input logic [2:0] tag,
                                              input int idx);
      logic [7:0] pat;
      pat = 8'h5a ^ {5'd0, tag};
      return (addr + 64'(idx) * 64'd8) ^ {8{pat}};
   endfunction

   task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
   endtask

   task automatic fail_note(input string msg);
      errors++;
      $display("at %0t: %s", $time, msg);
   endtask

   // queue one pio write, expand its blocks if the dma will keep it
   task automatic push_desc(input logic [54:0] blk, input logic [7:0] count, input bit kept);
      logic [31:0] junk;
      int i;
      junk = next_random();
      pio_q.push_back({blk, junk[0], count});   // bit 8 random, must be ignored
      if (!kept)
         n_drop++;
      else if (count != 8'd0) begin
         n_desc_nz++;
         for (i = 0; i < count; i++)
            exp_addr.push_back({blk, 9'd0} + 64'(i) * 64'd512);
      end
   endtask

   task automatic take_request();
      logic [63:0] exp;
      int i;
      exp = o_rr_addr;
      if (exp_addr.size() == 0)
         fail_note("request accepted with no descriptor block left");
      else begin
         exp = exp_addr.pop_front();
         if (o_rr_addr !== exp)
            value_error("o_rr_addr", exp, o_rr_addr);
      end
      if (o_rr_tag !== 3'(n_acc))
         value_error("o_rr_tag", 64'(3'(n_acc)), 64'(o_rr_tag));
      if (n_acc > 0 && cycle - last_acc < MIN_GAP)
         fail_note($sformatf("acceptances only %0d cycles apart", cycle - last_acc));
      if (n_acc + 1 - credited > MAX_OUT)
         fail_note("more than 6 blocks requested and not drained");
      for (i = 0; i < 64; i++)
         exp_words.push_back(word_value(exp, 3'(n_acc), i));
      blk_addr.push_back(o_rr_addr);   // completer answers what was asked
      blk_tag.push_back(o_rr_tag);
      blk_sent.push_back(64'd0);
      n_acc++;
      last_acc = cycle;
   endtask

   // one word of a random in-flight block, word 63 held back to the end
   task automatic send_completion();
      logic [31:0] r;
      logic [63:0] m;
      int k, idx, start, j;
      r = next_random();
      k = r[15:0] % blk_addr.size();
      m = blk_sent[k];
      start = r[31:16] % 63;
      idx = 63;
      for (j = 0; j < 63; j++)
         if (idx == 63 && !m[(start + j) % 63])
            idx = (start + j) % 63;
      i_rc_valid = 1'b1;
      i_rc_tag = {CHANNEL, 1'b0, blk_tag[k]};
      i_rc_index = 6'(idx);
      i_rx_data = word_value(blk_addr[k], blk_tag[k], idx);
      if (idx == 63) begin
         blk_addr.delete(k);
         blk_tag.delete(k);
         blk_sent.delete(k);
      end else
         blk_sent[k] = m | (64'd1 << idx);
   endtask

   task automatic tick();
      logic [31:0] r;
      logic [63:0] exp;
      @(negedge clock);
      cycle++;
      if (o_interrupt[0])
         n_int0++;
      if (o_interrupt[1])
         n_int1++;
      r = next_random();
      if (low_stretch > 0) begin
         low_stretch--;
         i_fifo_read = 1'b0;   // consumer stalled
      end else if (r[13:6] == 8'd0) begin
         low_stretch = 50 + r[19:12];
         i_fifo_read = 1'b0;
      end else
         i_fifo_read = (r[1:0] != 2'd0);
      if (i_fifo_read && o_fifo_valid) begin
         if (exp_words.size() == 0)
            fail_note("output word with nothing expected");
         else begin
            exp = exp_words.pop_front();
            if (o_fifo_data !== exp)
               value_error("o_fifo_data", exp, o_fifo_data);
         end
         words_read++;
         // a block leaving the ram has at most 18 words unread, so credit it at word 45
         if (words_read % 64 == 46)
            credited++;
      end
      r = next_random();
      i_rr_ready = 1'b0;
      if (o_rr_valid && !hold_ready && r[1:0] == 2'd0) begin
         i_rr_ready = 1'b1;
         take_request();
      end
      i_pio_wvalid = 1'b0;   // rx bus shared, one user per cycle
      i_rc_valid = 1'b0;
      i_rc_tag = 8'd0;
      i_rc_index = 6'd0;
      i_rx_data = 64'd0;
      r = next_random();
      if (pio_q.size() != 0) begin
         i_pio_wvalid = 1'b1;
         i_rx_data = pio_q.pop_front();
      end else if (blk_addr.size() != 0 && r[1:0] != 2'd0)
         send_completion();
      else if (r[7:4] == 4'd0) begin
         i_rc_valid = 1'b1;   // other channel, must not land in the ram
         i_rc_tag = {4'(1 + r[11:8] % 15), r[15:12]};
         i_rc_index = r[21:16];
         i_rx_data = {r, ~r};
      end
   endtask

   task automatic finish_run();
      $display("errors %0d, requests %0d, words read %0d", errors, n_acc, words_read);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   endtask

   initial begin
      int n, d;
      logic [31:0] r;
      rng = 32'h2d17;
      i_pio_wvalid = 1'b0;
      i_rc_valid = 1'b0;
      i_rr_ready = 1'b0;
      i_fifo_read = 1'b0;
      i_rx_data = 64'd0;
      i_rc_tag = 8'd0;
      i_rc_index = 6'd0;
      errors = 0;
      cycle = 0;
      n_acc = 0;
      last_acc = 0;
      words_read = 0;
      credited = 0;
      n_desc_nz = 0;
      n_drop = 0;
      n_int0 = 0;
      n_int1 = 0;
      low_stretch = 0;
      hold_ready = 1'b0;
      timed_out = 1'b0;
      @(posedge clock);
      n = 0;
      while (reset && n < 100) begin
         @(posedge clock);
         n++;
      end
      if (reset) begin
         fail_note("reset never released");
         timed_out = 1'b1;
      end
      @(negedge clock);
      if (o_rr_valid !== 1'b0)
         value_error("o_rr_valid", 64'd0, 64'(o_rr_valid));
      if (o_fifo_valid !== 1'b0)
         value_error("o_fifo_valid", 64'd0, 64'(o_fifo_valid));
      if (o_interrupt !== 2'd0)
         value_error("o_interrupt", 64'd0, 64'(o_interrupt));
      if (o_status !== 32'd0)
         value_error("o_status", 64'd0, 64'(o_status));
      // random descriptors, zero counts among them, queue never fills
      for (d = 0; d < 12 && !timed_out; d++) begin
         r = next_random();
         push_desc(random_block(), 8'(r[7:0] % 6), 1'b1);
         repeat (r[15:8]) tick();
      end
      n = 0;
      while (exp_addr.size() != 0 && n < 100000 && !timed_out) begin
         tick();
         n++;
      end
      if (exp_addr.size() != 0 && !timed_out) begin
         fail_note("timeout waiting for all blocks to be requested");
         timed_out = 1'b1;
      end
      if (!timed_out) begin
         // stall acceptance, one descriptor active, 16 queued, 4 dropped
         hold_ready = 1'b1;
         push_desc(random_block(), 8'd3, 1'b1);
         repeat (4) tick();
         for (d = 0; d < 20; d++)
            push_desc(random_block(), 8'(1 + d % 4), d < 16);
         n = 0;
         while (pio_q.size() != 0 && n < 1000) begin
            tick();
            n++;
         end
         if (pio_q.size() != 0) begin
            fail_note("timeout waiting for pio writes to go out");
            timed_out = 1'b1;
         end
         repeat (4) tick();
         if (o_status[31:16] !== 16'd16)
            value_error("o_status[31:16]", 64'd16, 64'(o_status[31:16]));
         hold_ready = 1'b0;
      end
      n = 0;
      while (exp_addr.size() + blk_addr.size() + exp_words.size() != 0 && n < 400000
             && !timed_out) begin
         tick();
         n++;
      end
      if (exp_addr.size() + blk_addr.size() + exp_words.size() != 0 && !timed_out) begin
         fail_note("timeout waiting for all words to be read out");
         timed_out = 1'b1;
      end
      if (!timed_out) begin
         repeat (20) tick();
         if (o_fifo_valid !== 1'b0)
            value_error("o_fifo_valid", 64'd0, 64'(o_fifo_valid));
         if (o_status[15:0] !== 16'(n_acc))
            value_error("o_status[15:0]", 64'(16'(n_acc)), 64'(o_status[15:0]));
         if (o_status[31:16] !== 16'd0)
            value_error("o_status[31:16]", 64'd0, 64'(o_status[31:16]));
         if (n_int0 != n_desc_nz)
            value_error("o_interrupt[0] pulses", 64'(n_desc_nz), 64'(n_int0));
         if (n_int1 != n_drop)
            value_error("o_interrupt[1] pulses", 64'(n_drop), 64'(n_int1));
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- rtl/completion_reorder.sv
`timescale 1ns/1ps
`default_nettype none

// stores completions by tag and index, drains whole blocks in order
module completion_reorder #(
   parameter logic [3:0] CHANNEL = 4'd0,
   parameter int OUT_DEPTH_LOG2 = 4
) (
   input  wire logic clock,
   input  wire logic reset,
   hififo_rc_if.sink rc,
   output logic o_drain_slot_advance,
   input  wire logic i_fifo_read,
   output hififo_pkg::data_t o_fifo_data,
   output logic o_fifo_valid
);

   localparam int IDX_W = hififo_pkg::BLOCK_WORDS_LOG2;
   localparam int ADDR_W = hififo_pkg::SLOT_LOG2 + IDX_W;

   logic wr_en, wr_last;
   hififo_pkg::slot_t wr_slot;
   logic [2**hififo_pkg::SLOT_LOG2-1:0] block_filled;   // one flag per slot
   logic [ADDR_W-1:0] p_read;   // {slot, index}
   hififo_pkg::slot_t rd_slot;
   hififo_pkg::index_t rd_index;
   logic draining, advance, fifo_ready;
   logic fifo_write_0, fifo_write_1;   // ram stage, register stage
   hififo_pkg::data_t ram_data;
   hififo_pkg::data_t fifo_in_data;

   assign wr_en = rc.valid && (rc.tag[7:4] == CHANNEL);   // other channels ignored
   assign wr_slot = rc.tag[hififo_pkg::SLOT_LOG2-1:0];
   assign wr_last = wr_en && (rc.index == '1);   // word 63 closes the block
   assign rd_slot = p_read[ADDR_W-1:IDX_W];
   assign rd_index = p_read[IDX_W-1:0];
   // filled flag starts a block, nonzero index keeps it going
   assign draining = block_filled[rd_slot] || (rd_index != '0);
   assign advance = draining && fifo_ready;
   assign o_drain_slot_advance = advance && (rd_index == '1);

   reorder_ram #(.DATA_W(hififo_pkg::DATA_W), .ADDR_W(ADDR_W)) ram (
      .i_clock   (clock),
      .i_wr_en   (wr_en),
      .i_wr_addr ({wr_slot, rc.index}),
      .i_wr_data (rc.data),
      .i_rd_addr (p_read),
      .o_rd_data (ram_data)
   );

   always_ff @(posedge clock) begin
      if (reset) begin
         block_filled <= '0;
         p_read <= '0;
         fifo_write_0 <= 1'b0;
         fifo_write_1 <= 1'b0;
      end else begin
         if (advance && (rd_index == '0))
            block_filled[rd_slot] <= 1'b0;   // drain begins
         if (wr_last)
            block_filled[wr_slot] <= 1'b1;
         if (advance)
            p_read <= p_read + 1'b1;   // wraps to slot 0
         fifo_write_0 <= advance;
         fifo_write_1 <= fifo_write_0;
      end
   end

   always_ff @(posedge clock)
      fifo_in_data <= ram_data;

   fwft_fifo #(.payload_t(hififo_pkg::data_t), .DEPTH_LOG2(OUT_DEPTH_LOG2)) out_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_wr    (fifo_write_1),
      .i_data  (fifo_in_data),
      .o_ready (fifo_ready),   // slack covers both stages
      .i_rd    (i_fifo_read),
      .o_data  (o_fifo_data),
      .o_valid (o_fifo_valid),
      .o_count ()
   );

endmodule

`default_nettype wire

//--- rtl/fetch_descriptor.sv
`timescale 1ns/1ps
`default_nettype none

// descriptor queue from pio writes, steps through block addresses
module fetch_descriptor #(
   parameter int DESC_DEPTH_LOG2 = 4
) (
   input  wire logic clock,
   input  wire logic reset,
   input  wire logic i_pio_wvalid,
   input  wire hififo_pkg::data_t i_pio_data,
   output logic o_req_pending,
   output logic [63:0] o_req_addr,
   input  wire logic i_req_taken,
   output logic [31:0] o_status,
   output logic [1:0] o_interrupt
);

   localparam logic [DESC_DEPTH_LOG2:0] QUEUE_FULL =
      (DESC_DEPTH_LOG2+1)'(2**DESC_DEPTH_LOG2);

   hififo_pkg::desc_t pio_desc;
   hififo_pkg::desc_t head_desc;
   logic q_wr, q_rd, q_valid, q_full;
   logic [DESC_DEPTH_LOG2:0] q_count;
   logic [54:0] cur_addr;    // current block, byte address >> 9
   logic [7:0] cur_count;    // blocks left incl. current
   logic cur_valid;
   logic last_taken;
   logic [15:0] n_taken;     // accepted requests, wraps

   assign pio_desc.addr = i_pio_data[63:9];
   assign pio_desc.count = i_pio_data[7:0];   // bit 8 ignored
   assign q_full = (q_count == QUEUE_FULL);
   assign q_wr = i_pio_wvalid && !q_full && (pio_desc.count != '0);   // zero counts vanish
   assign q_rd = q_valid && !cur_valid;   // load head when idle
   assign last_taken = i_req_taken && cur_valid && (cur_count == 8'd1);

   assign o_req_pending = cur_valid;
   assign o_req_addr = {cur_addr, 9'd0};
   assign o_status = {16'(q_count), n_taken};

   fwft_fifo #(.payload_t(hififo_pkg::desc_t), .DEPTH_LOG2(DESC_DEPTH_LOG2)) desc_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_wr    (q_wr),
      .i_data  (pio_desc),
      .o_ready (),           // full test uses the count
      .i_rd    (q_rd),
      .o_data  (head_desc),
      .o_valid (q_valid),
      .o_count (q_count)
   );

   always_ff @(posedge clock) begin
      if (reset) begin
         cur_valid <= 1'b0;
         n_taken <= '0;
         o_interrupt <= '0;
      end else begin
         o_interrupt[1] <= i_pio_wvalid && q_full;   // write dropped
         o_interrupt[0] <= last_taken;                // descriptor done
         if (i_req_taken)
            n_taken <= n_taken + 1'b1;
         if (q_rd)
            cur_valid <= 1'b1;
         else if (last_taken)
            cur_valid <= 1'b0;
      end
   end

   always_ff @(posedge clock) begin
      if (q_rd) begin
         cur_addr <= head_desc.addr;
         cur_count <= head_desc.count;
      end else if (i_req_taken) begin
         cur_addr <= cur_addr + 1'b1;   // +512 bytes
         cur_count <= cur_count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/fwft_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// single clock fifo, head word falls through to o_data
module fwft_fifo #(
   parameter type payload_t = logic [63:0],
   parameter int DEPTH_LOG2 = 4
) (
   input  wire logic clock,
   input  wire logic reset,
   input  wire logic i_wr,
   input  wire payload_t i_data,
   output logic o_ready,
   input  wire logic i_rd,
   output payload_t o_data,
   output logic o_valid,
   output logic [DEPTH_LOG2:0] o_count
);

   localparam int DEPTH = 2**DEPTH_LOG2;
   localparam logic [DEPTH_LOG2:0] FULL = (DEPTH_LOG2+1)'(DEPTH);
   // ready while 3 or more entries free, room for 2 words in flight
   localparam logic [DEPTH_LOG2:0] READY_MAX = (DEPTH_LOG2+1)'(DEPTH - 3);

   payload_t mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0] count;   // occupancy
   logic do_wr;
   logic do_rd;

   assign do_wr = i_wr && (count != FULL);   // never overwrite
   assign do_rd = i_rd && o_valid;           // pop only a valid head
   assign o_valid = (count != '0);
   assign o_data = mem[rd_ptr];
   assign o_ready = (count <= READY_MAX);
   assign o_count = count;

   always_ff @(posedge clock) begin
      if (do_wr)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;   // wraps
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/hififo_pkg.sv
`default_nettype none

package hififo_pkg;

   localparam int DATA_W = 64;            // pcie payload word
   localparam int BLOCK_WORDS_LOG2 = 6;   // 64 words of 8 bytes = 512 byte block
   localparam int SLOT_LOG2 = 3;          // 8 reorder slots, also the tag width
   localparam int MAX_OUTSTANDING = 6;    // blocks requested but not drained
   localparam int HOLDOFF = 3;            // idle cycles after each accepted request

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SLOT_LOG2-1:0] slot_t;
   typedef logic [BLOCK_WORDS_LOG2-1:0] index_t;

   // pio word layout
   // 63..9 block address, 8 unused, 7..0 block count
   typedef struct packed {
      logic [54:0] addr;   // byte address >> 9
      logic [7:0] count;   // number of 512 byte blocks
   } desc_t;

endpackage

`default_nettype wire

//--- rtl/hififo_rc_if.sv
`timescale 1ns/1ps
`default_nettype none

// read completion bundle, one word per strobe
interface hififo_rc_if;

   hififo_pkg::data_t data;     // completion payload
   logic [7:0] tag;             // channel in 7..4, slot in 2..0
   hififo_pkg::index_t index;   // word within the block
   logic valid;                 // single cycle strobe

   modport source (
      output data,
      output tag,
      output index,
      output valid
   );

   modport sink (
      input data,
      input tag,
      input index,
      input valid
   );

endinterface

`default_nettype wire

//--- rtl/pcie_from_pc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// host to card dma channel top
module pcie_from_pc_fifo #(
   parameter logic [3:0] CHANNEL = 4'd0,
   parameter int DESC_DEPTH_LOG2 = 4,
   parameter int OUT_DEPTH_LOG2 = 4
) (
   input  wire logic clock,
   input  wire logic reset,
   input  wire logic i_pio_wvalid,
   input  wire hififo_pkg::data_t i_rx_data,   // pio writes and completions
   input  wire logic [7:0] i_rc_tag,
   input  wire hififo_pkg::index_t i_rc_index,
   input  wire logic i_rc_valid,
   output logic o_rr_valid,
   output logic [63:0] o_rr_addr,
   output hififo_pkg::slot_t o_rr_tag,
   input  wire logic i_rr_ready,
   input  wire logic i_fifo_read,
   output hififo_pkg::data_t o_fifo_data,
   output logic o_fifo_valid,
   output logic [31:0] o_status,
   output logic [1:0] o_interrupt
);

   hififo_rc_if rc ();
   logic req_pending;
   logic req_taken;
   logic drain_slot_advance;
   logic [63:0] req_addr;

   // completion ports into the bundle
   assign rc.data = i_rx_data;
   assign rc.tag = i_rc_tag;
   assign rc.index = i_rc_index;
   assign rc.valid = i_rc_valid;

   fetch_descriptor #(.DESC_DEPTH_LOG2(DESC_DEPTH_LOG2)) fetch (
      .clock         (clock),
      .reset         (reset),
      .i_pio_wvalid  (i_pio_wvalid),
      .i_pio_data    (i_rx_data),
      .o_req_pending (req_pending),
      .o_req_addr    (req_addr),
      .i_req_taken   (req_taken),
      .o_status      (o_status),
      .o_interrupt   (o_interrupt)
   );

   request_pacer pacer (
      .clock                (clock),
      .reset                (reset),
      .i_req_pending        (req_pending),
      .i_req_addr           (req_addr),
      .o_req_taken          (req_taken),
      .i_drain_slot_advance (drain_slot_advance),
      .o_rr_valid           (o_rr_valid),
      .o_rr_addr            (o_rr_addr),
      .o_rr_tag             (o_rr_tag),
      .i_rr_ready           (i_rr_ready)
   );

   completion_reorder #(.CHANNEL(CHANNEL), .OUT_DEPTH_LOG2(OUT_DEPTH_LOG2)) reorder (
      .clock                (clock),
      .reset                (reset),
      .rc                   (rc.sink),
      .o_drain_slot_advance (drain_slot_advance),
      .i_fifo_read          (i_fifo_read),
      .o_fifo_data          (o_fifo_data),
      .o_fifo_valid         (o_fifo_valid)
   );

endmodule

`default_nettype wire

//--- rtl/reorder_ram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual port ram, write port and one registered read port
module reorder_ram #(
   parameter int DATA_W = 64,
   parameter int ADDR_W = 9
) (
   input  wire logic i_clock,
   input  wire logic i_wr_en,
   input  wire logic [ADDR_W-1:0] i_wr_addr,
   input  wire logic [DATA_W-1:0] i_wr_data,
   input  wire logic [ADDR_W-1:0] i_rd_addr,
   output logic [DATA_W-1:0] o_rd_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];   // slot-major, word index minor

   always_ff @(posedge i_clock) begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
      o_rd_data <= mem[i_rd_addr];   // read every cycle, 1 cycle latency
   end

endmodule

`default_nettype wire

//--- rtl/request_pacer.sv
`timescale 1ns/1ps
`default_nettype none

// read request strobe, tag and outstanding limit
module request_pacer (
   input  wire logic clock,
   input  wire logic reset,
   input  wire logic i_req_pending,
   input  wire logic [63:0] i_req_addr,
   output logic o_req_taken,
   input  wire logic i_drain_slot_advance,
   output logic o_rr_valid,
   output logic [63:0] o_rr_addr,
   output hififo_pkg::slot_t o_rr_tag,
   input  wire logic i_rr_ready
);

   localparam logic [1:0] HOLDOFF = 2'(hififo_pkg::HOLDOFF);
   localparam logic [3:0] MAX_OUT = 4'(hififo_pkg::MAX_OUTSTANDING);

   hififo_pkg::slot_t p_request;   // request count mod 8, also the tag
   logic [3:0] outstanding;        // accepted minus drained
   logic [1:0] holdoff;
   logic accept;

   assign accept = o_rr_valid && i_rr_ready;
   assign o_req_taken = accept;   // fetch steps address same cycle
   assign o_rr_tag = p_request;

   always_ff @(posedge clock) begin
      if (reset) begin
         o_rr_valid <= 1'b0;
         p_request <= '0;
         outstanding <= '0;
         holdoff <= '0;
      end else begin
         // drop after acceptance, then wait out the holdoff
         o_rr_valid <= !accept && i_req_pending && (outstanding < MAX_OUT)
                       && (holdoff == '0);
         if (accept)
            p_request <= p_request + 1'b1;
         if (accept)
            holdoff <= HOLDOFF;
         else if (holdoff != '0)
            holdoff <= holdoff - 1'b1;
         case ({accept, i_drain_slot_advance})
            2'b10: outstanding <= outstanding + 1'b1;
            2'b01: outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
         endcase
      end
   end

   always_ff @(posedge clock)
      o_rr_addr <= i_req_addr;   // stable until taken

endmodule

`default_nettype wire
